//--- common/cpuPkg.sv
// shared CPU definitions for the decode stage
// word width plus the MIPS opcode, function, ALU and bypass encodings
package cpuPkg;

    localparam int dataW = 32;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeE;

    // function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functE;

    // operation handed to EXE
    typedef enum logic [3:0] {
        aluNop = 4'd0,
        aluAdd = 4'd1,
        aluSub = 4'd2,
        aluAnd = 4'd3,
        aluOr  = 4'd4,
        aluSlt = 4'd5,
        aluLui = 4'd6
    } aluOpE;

    // operand source, same order as the 4:1 bypass mux inputs
    typedef enum logic [1:0] {
        fwdRf   = 2'd0,
        fwdMem  = 2'd1,
        fwdMem2 = 2'd2,
        fwdWb   = 2'd3
    } fwdSelE;

endpackage

//--- decode/idReg.sv
// IF/ID pipeline register
// holds instruction and PC, with write enable and flush to a NOP
module idReg
    import cpuPkg::*;
#(
    parameter logic [dataW-1:0] resetPc = 32'h0
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             idWr,
    input  logic             idFlush,
    input  logic [dataW-1:0] ifInstr,
    input  logic [dataW-1:0] ifPc,
    output logic [dataW-1:0] idInstr,
    output logic [dataW-1:0] idPc
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idInstr <= '0;             // NOP
            idPc    <= resetPc;
        end else if (idFlush) begin
            // flush beats idWr, pc stays put
            idInstr <= '0;
        end else if (idWr) begin
            idInstr <= ifInstr;
            idPc    <= ifPc;
        end
    end

endmodule

//--- decode/regFile.sv
// 32 x 32-bit register file
// two asynchronous reads, one write from WB, r0 fixed at zero
module regFile
    import cpuPkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             wbRegWrite,
    input  logic [4:0]       wbDst,
    input  logic [dataW-1:0] wbResult,
    input  logic [4:0]       rs,
    input  logic [4:0]       rt,
    output logic [dataW-1:0] rfA,
    output logic [dataW-1:0] rfB
);

    logic [dataW-1:0] regs [1:31];   // no storage for r0

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRegWrite && (wbDst != 5'd0)) begin
            regs[wbDst] <= wbResult;
        end
    end

    // same-cycle WB writes are covered by the bypass, not here
    assign rfA = (rs == 5'd0) ? '0 : regs[rs];
    assign rfB = (rt == 5'd0) ? '0 : regs[rt];

endmodule

//--- decode/instrDecoder.sv
// instruction decoder for the MIPS32 integer subset
// produces ALU op, extended immediate, destination and control flags
module instrDecoder
    import cpuPkg::*;
(
    input  logic [dataW-1:0] instr,
    output aluOpE            aluOp,
    output logic [dataW-1:0] imm32,
    output logic [4:0]       dst,
    output logic             regWrite,
    output logic             memRead,
    output logic             memWrite,
    output logic             isJump,
    output logic             isBranch,
    output logic             isBne,
    output logic             readsRs,
    output logic             readsRt,
    output logic             reservedInstr
);

    opcodeE      op;
    functE       fn;
    logic [4:0]  rtF;
    logic [4:0]  rdF;
    logic [15:0] imm16;
    logic [dataW-1:0] immSext;
    logic [dataW-1:0] immZext;

    assign op    = opcodeE'(instr[31:26]);
    assign fn    = functE'(instr[5:0]);
    assign rtF   = instr[20:16];
    assign rdF   = instr[15:11];
    assign imm16 = instr[15:0];

    assign immSext = {{16{imm16[15]}}, imm16};
    assign immZext = {16'h0000, imm16};

    always_comb begin
        // defaults give the NOP decode
        aluOp         = aluNop;
        imm32         = '0;
        dst           = 5'd0;
        regWrite      = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        isJump        = 1'b0;
        isBranch      = 1'b0;
        isBne         = 1'b0;
        readsRs       = 1'b0;
        readsRt       = 1'b0;
        reservedInstr = 1'b0;

        unique case (op)
            opSpecial: begin
                if (instr != '0) begin   // all-zero word is the NOP
                    dst      = rdF;
                    regWrite = 1'b1;
                    readsRs  = 1'b1;
                    readsRt  = 1'b1;
                    case (fn)
                        fnAddu:  aluOp = aluAdd;
                        fnSubu:  aluOp = aluSub;
                        fnAnd:   aluOp = aluAnd;
                        fnOr:    aluOp = aluOr;
                        fnSlt:   aluOp = aluSlt;
                        default: begin
                            reservedInstr = 1'b1;
                            regWrite      = 1'b0;
                            dst           = 5'd0;
                            readsRs       = 1'b0;
                            readsRt       = 1'b0;
                        end
                    endcase
                end
            end
            opAddiu: begin
                aluOp = aluAdd; imm32 = immSext;
                dst = rtF; regWrite = 1'b1; readsRs = 1'b1;
            end
            opAndi: begin
                aluOp = aluAnd; imm32 = immZext;
                dst = rtF; regWrite = 1'b1; readsRs = 1'b1;
            end
            opOri: begin
                aluOp = aluOr; imm32 = immZext;
                dst = rtF; regWrite = 1'b1; readsRs = 1'b1;
            end
            opLui: begin
                aluOp    = aluLui;
                imm32    = {imm16, 16'h0000};
                dst      = rtF;
                regWrite = 1'b1;           // rs field ignored
            end
            opLw: begin
                aluOp = aluAdd; imm32 = immSext;
                dst = rtF; regWrite = 1'b1; memRead = 1'b1; readsRs = 1'b1;
            end
            opSw: begin
                aluOp = aluAdd; imm32 = immSext;
                memWrite = 1'b1; readsRs = 1'b1; readsRt = 1'b1;  // rt is store data
            end
            opBeq, opBne: begin
                aluOp    = aluSub;
                imm32    = immSext;
                isBranch = 1'b1;
                isBne    = (op == opBne);
                readsRs  = 1'b1;
                readsRt  = 1'b1;
            end
            opJ:   isJump = 1'b1;
            opJal: begin
                isJump   = 1'b1;
                dst      = 5'd31;          // link register
                regWrite = 1'b1;
            end
            default: reservedInstr = 1'b1;
        endcase
    end

endmodule

//--- decode/bypassUnit.sv
// ID operand bypass
// selects RF, MEM, MEM2 or WB data per operand, nearest stage first
module bypassUnit
    import cpuPkg::*;
(
    input  logic [4:0]       rs,
    input  logic [4:0]       rt,
    input  logic [dataW-1:0] rfA,
    input  logic [dataW-1:0] rfB,
    input  logic [4:0]       memDst,
    input  logic             memRegWrite,
    input  logic [dataW-1:0] memResult,
    input  logic [4:0]       mem2Dst,
    input  logic             mem2RegWrite,
    input  logic [dataW-1:0] mem2Result,
    input  logic [4:0]       wbDst,
    input  logic             wbRegWrite,
    input  logic [dataW-1:0] wbResult,
    output logic [dataW-1:0] busA,
    output logic [dataW-1:0] busB
);

    fwdSelE selA;
    fwdSelE selB;

    // priority MEM > MEM2 > WB, r0 never forwarded
    function automatic fwdSelE pickSrc(input logic [4:0] src);
        if (src == 5'd0)                         return fwdRf;
        else if (memRegWrite && memDst == src)   return fwdMem;
        else if (mem2RegWrite && mem2Dst == src) return fwdMem2;
        else if (wbRegWrite && wbDst == src)     return fwdWb;
        else                                     return fwdRf;
    endfunction

    function automatic logic [dataW-1:0] muxSrc(input fwdSelE sel,
                                                input logic [dataW-1:0] rfVal);
        case (sel)
            fwdMem:  return memResult;
            fwdMem2: return mem2Result;
            fwdWb:   return wbResult;
            default: return rfVal;
        endcase
    endfunction

    // later-stage signals are read inside the functions
    always_comb begin
        selA = pickSrc(rs);
        selB = pickSrc(rt);
        busA = muxSrc(selA, rfA);
        busB = muxSrc(selB, rfB);
    end

endmodule

//--- decode/loadHazard.sv
// load-use hazard detection
// stalls ID while a read source waits on a load in EXE or MEM
module loadHazard (
    input  logic       readsRs,
    input  logic       readsRt,
    input  logic [4:0] rs,
    input  logic [4:0] rt,
    input  logic [4:0] exeRt,
    input  logic       exeMemRead,
    input  logic [4:0] memRt,
    input  logic       memMemRead,
    output logic       exeStall,
    output logic       memStall
);

    // load target hits a source the decoder marked as read
    function automatic logic loadHit(input logic load, input logic [4:0] tgt);
        logic hitRs;
        logic hitRt;
        hitRs = readsRs && (rs == tgt);
        hitRt = readsRt && (rt == tgt);
        return load && (tgt != 5'd0) && (hitRs || hitRt);
    endfunction

    always_comb begin
        exeStall = loadHit(exeMemRead, exeRt);
        memStall = loadHit(memMemRead, memRt);   // MEM2 data is bypassed instead
    end

endmodule

//--- decode/decodeStage.sv
// instruction decode stage top
// IF/ID register, register file, decoder, bypass and load-use stall logic
module decodeStage
    import cpuPkg::*;
#(
    parameter logic [dataW-1:0] resetPc = 32'h0
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             idWr,
    input  logic             idFlush,
    input  logic             disableWr,
    input  logic [dataW-1:0] ifInstr,
    input  logic [dataW-1:0] ifPc,
    input  logic [4:0]       memDst,
    input  logic             memRegWrite,
    input  logic [dataW-1:0] memResult,
    input  logic [4:0]       mem2Dst,
    input  logic             mem2RegWrite,
    input  logic [dataW-1:0] mem2Result,
    input  logic [4:0]       wbDst,
    input  logic             wbRegWrite,
    input  logic [dataW-1:0] wbResult,
    input  logic [4:0]       exeRt,
    input  logic             exeMemRead,
    input  logic [4:0]       memRt,
    input  logic             memMemRead,
    output logic [dataW-1:0] idInstr,
    output logic [dataW-1:0] idPc,
    output logic [4:0]       rs,
    output logic [4:0]       rt,
    output logic [dataW-1:0] busA,
    output logic [dataW-1:0] busB,
    output logic [dataW-1:0] imm32,
    output aluOpE            aluOp,
    output logic [4:0]       dst,
    output logic             regWrite,
    output logic             memRead,
    output logic             memWrite,
    output logic             isJump,
    output logic             isBranch,
    output logic             isBne,
    output logic             reservedInstr,
    output logic             exeStall,
    output logic             memStall
);

    logic [dataW-1:0] rfA;
    logic [dataW-1:0] rfB;
    logic             decRegWrite;
    logic             decMemRead;
    logic             decMemWrite;
    logic             readsRs;
    logic             readsRt;

    assign rs = idInstr[25:21];
    assign rt = idInstr[20:16];

    // disableWr cancels only the side effects
    assign regWrite = decRegWrite & ~disableWr;
    assign memRead  = decMemRead  & ~disableWr;
    assign memWrite = decMemWrite & ~disableWr;

    idReg #(.resetPc(resetPc)) idReg_i (
        .clk     (clk),
        .arstN   (arstN),
        .idWr    (idWr),
        .idFlush (idFlush),
        .ifInstr (ifInstr),
        .ifPc    (ifPc),
        .idInstr (idInstr),
        .idPc    (idPc)
    );

    regFile regFile_i (
        .clk        (clk),
        .arstN      (arstN),
        .wbRegWrite (wbRegWrite),
        .wbDst      (wbDst),
        .wbResult   (wbResult),
        .rs         (rs),
        .rt         (rt),
        .rfA        (rfA),
        .rfB        (rfB)
    );

    instrDecoder instrDecoder_i (
        .instr         (idInstr),
        .aluOp         (aluOp),
        .imm32         (imm32),
        .dst           (dst),
        .regWrite      (decRegWrite),
        .memRead       (decMemRead),
        .memWrite      (decMemWrite),
        .isJump        (isJump),
        .isBranch      (isBranch),
        .isBne         (isBne),
        .readsRs       (readsRs),
        .readsRt       (readsRt),
        .reservedInstr (reservedInstr)
    );

    bypassUnit bypassUnit_i (
        .rs           (rs),
        .rt           (rt),
        .rfA          (rfA),
        .rfB          (rfB),
        .memDst       (memDst),
        .memRegWrite  (memRegWrite),
        .memResult    (memResult),
        .mem2Dst      (mem2Dst),
        .mem2RegWrite (mem2RegWrite),
        .mem2Result   (mem2Result),
        .wbDst        (wbDst),
        .wbRegWrite   (wbRegWrite),
        .wbResult     (wbResult),
        .busA         (busA),
        .busB         (busB)
    );

    loadHazard loadHazard_i (
        .readsRs    (readsRs),
        .readsRt    (readsRt),
        .rs         (rs),
        .rt         (rt),
        .exeRt      (exeRt),
        .exeMemRead (exeMemRead),
        .memRt      (memRt),
        .memMemRead (memMemRead),
        .exeStall   (exeStall),
        .memStall   (memStall)
    );

endmodule

//--- bench/decodeStage_chk.sv
// decode stage assertions
// flush, reserved instruction, disable-write and stall sanity
module decodeStage_chk (
    input logic        clk,
    input logic        arstN,
    input logic        idFlush,
    input logic        disableWr,
    input logic [31:0] idInstr,
    input logic        reservedInstr,
    input logic        regWrite,
    input logic        memWrite,
    input logic        exeMemRead,
    input logic        memMemRead,
    input logic        exeStall,
    input logic        memStall
);

    flushClears: assert property (@(posedge clk) disable iff (!arstN)
        idFlush |=> (idInstr == '0))
        else $error("idInstr not cleared after flush");

    reservedNoWrite: assert property (@(posedge clk) disable iff (!arstN)
        reservedInstr |-> !regWrite)
        else $error("regWrite high on a reserved instruction");

    disabledNoStore: assert property (@(posedge clk) disable iff (!arstN)
        disableWr |-> !memWrite)
        else $error("memWrite high while disableWr");

    stallNeedsLoad: assert property (@(posedge clk) disable iff (!arstN)
        (!exeMemRead && !memMemRead) |-> (!exeStall && !memStall))
        else $error("stall raised with no load in EXE or MEM");

endmodule

bind decodeStage decodeStage_chk chk_i (.*);

//--- bench/decodeStage_tb.sv
// testbench for the instruction decode stage
// directed tests against a reference register array and decode table
module decodeStage_tb
    import cpuPkg::*;
();

    localparam logic [31:0] resetPc   = 32'hbfc00000;
    localparam int          clkPeriod = 10;
    // reset, pipe reg, decode, regfile, bypass, hazards, disable-write
    localparam int          testCycles = 10 + 8 + 102 + 40 + 10 + 14 + 8;

    // {opcode, funct}, funct only matters for SPECIAL
    localparam logic [11:0] decodeCodes [17] = '{
        {6'h00, 6'h21}, {6'h00, 6'h23}, {6'h00, 6'h24}, {6'h00, 6'h25}, {6'h00, 6'h2a},
        {6'h00, 6'h3f}, {6'h09, 6'h00}, {6'h0c, 6'h00}, {6'h0d, 6'h00}, {6'h0f, 6'h00},
        {6'h23, 6'h00}, {6'h2b, 6'h00}, {6'h04, 6'h00}, {6'h05, 6'h00}, {6'h02, 6'h00},
        {6'h03, 6'h00}, {6'h3e, 6'h00}
    };

    logic        clk, arstN, idWr, idFlush, disableWr;
    logic [31:0] ifInstr, ifPc, memResult, mem2Result, wbResult;
    logic [4:0]  memDst, mem2Dst, wbDst, exeRt, memRt;
    logic        memRegWrite, mem2RegWrite, wbRegWrite, exeMemRead, memMemRead;
    logic [31:0] idInstr, idPc, busA, busB, imm32;
    logic [4:0]  rs, rt, dst;
    aluOpE       aluOp;
    logic        regWrite, memRead, memWrite, isJump, isBranch, isBne, reservedInstr;
    logic        exeStall, memStall;

    logic [31:0] refRegs [32];
    aluOpE       expAlu;
    logic [31:0] expImm;
    logic [4:0]  expDst;
    logic [6:0]  expFlags;      // regWrite memRead memWrite isJump isBranch isBne reserved
    int          errorCount = 0;
    int          checkCount = 0;
    int unsigned seedVal;

    decodeStage #(.resetPc(resetPc)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // register file model, follows the WB port
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                refRegs[i] <= '0;
            end
        end else if (wbRegWrite && wbDst != 5'd0) begin
            refRegs[wbDst] <= wbResult;
        end
    end

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // one cycle through the IF/ID register
    task automatic loadInstr(input logic [31:0] ins);
        ifInstr = ins;
        ifPc = ifPc + 32'd4;
        idWr = 1'b1;
        nextCycle();
        idWr = 1'b0;
    endtask

    task automatic writeReg(input logic [4:0] r, input logic [31:0] v);
        wbDst = r;
        wbResult = v;
        wbRegWrite = 1'b1;
        nextCycle();
        wbRegWrite = 1'b0;
    endtask

    function automatic logic [6:0] dutFlags();
        return {regWrite, memRead, memWrite, isJump, isBranch, isBne, reservedInstr};
    endfunction

    task automatic writeRt(input aluOpE op, input logic [31:0] imm, input logic [4:0] rtF);
        expAlu = op;
        expImm = imm;
        expDst = rtF;
        expFlags[6] = 1'b1;
    endtask

    // expected decode of the MIPS32 subset
    task automatic predict(input logic [31:0] ins);
        logic [31:0] sext;
        logic [31:0] zext;
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'h0000, ins[15:0]};
        expAlu = aluNop;
        expImm = '0;
        expDst = 5'd0;
        expFlags = '0;
        case (ins[31:26])
            6'h00: begin
                case (ins[5:0])
                    6'h21: expAlu = aluAdd;
                    6'h23: expAlu = aluSub;
                    6'h24: expAlu = aluAnd;
                    6'h25: expAlu = aluOr;
                    6'h2a: expAlu = aluSlt;
                    default: expFlags[0] = (ins != '0);   // the zero word is a NOP
                endcase
                if (expAlu != aluNop) begin
                    expDst = ins[15:11];
                    expFlags[6] = 1'b1;
                end
            end
            6'h09: writeRt(aluAdd, sext, ins[20:16]);
            6'h0c: writeRt(aluAnd, zext, ins[20:16]);
            6'h0d: writeRt(aluOr, zext, ins[20:16]);
            6'h0f: writeRt(aluLui, {ins[15:0], 16'h0000}, ins[20:16]);
            6'h23: begin
                writeRt(aluAdd, sext, ins[20:16]);
                expFlags[5] = 1'b1;
            end
            6'h2b: begin
                expAlu = aluAdd;
                expImm = sext;
                expFlags = 7'b0010000;
            end
            6'h04, 6'h05: begin
                expAlu = aluSub;
                expImm = sext;
                expFlags = {5'b00001, ins[26], 1'b0};   // bit 26 tells BNE from BEQ
            end
            6'h02: expFlags = 7'b0001000;
            6'h03: begin
                expDst = 5'd31;
                expFlags = 7'b1001000;
            end
            default: expFlags = 7'b0000001;
        endcase
    endtask

    task automatic checkDecode();
        checkVal("aluOp", aluOp, expAlu);
        checkVal("imm32", imm32, expImm);
        checkVal("dst", dst, expDst);
        checkVal("flags {regWrite..reservedInstr}", dutFlags(), expFlags);
    endtask

    task automatic testReset();
        logic [31:0] heldPc;
        @(negedge clk);
        checkVal("idPc", idPc, resetPc);
        checkVal("idInstr", idInstr, 32'h0);
        checkVal("flags {regWrite..reservedInstr}", dutFlags(), 7'h0);
        checkVal("{exeStall, memStall}", {exeStall, memStall}, 2'b00);
        nextCycle();
        loadInstr(32'h8ca4_0008);   // lw r4, 8(r5)
        heldPc = ifPc;
        @(negedge clk);
        checkVal("idInstr", idInstr, 32'h8ca4_0008);
        checkVal("idPc", idPc, heldPc);
        nextCycle();
        ifInstr = 32'h2402_1234;
        ifPc = ifPc + 32'd4;
        nextCycle();                // edge with idWr low
        @(negedge clk);
        checkVal("idInstr", idInstr, 32'h8ca4_0008);
        checkVal("idPc", idPc, heldPc);
        nextCycle();
        idWr = 1'b1;
        idFlush = 1'b1;
        nextCycle();
        idWr = 1'b0;
        idFlush = 1'b0;
        @(negedge clk);
        checkVal("idInstr", idInstr, 32'h0);
        checkVal("idPc", idPc, heldPc);
        nextCycle();
    endtask

    task automatic testDecode();
        logic [31:0] rnd;
        logic [31:0] ins;
        for (int i = 0; i < 17; i++) begin
            repeat (3) begin
                rnd = $urandom;
                ins = {decodeCodes[i][11:6], rnd[25:0]};
                if (decodeCodes[i][11:6] == 6'h00)
                    ins[5:0] = decodeCodes[i][5:0];
                loadInstr(ins);
                predict(ins);
                @(negedge clk);
                checkDecode();
                checkVal("rs", rs, ins[25:21]);
                checkVal("rt", rt, ins[20:16]);
                nextCycle();
            end
        end
    endtask

    task automatic testRegFile();
        logic [31:0] rnd;
        logic [4:0]  a;
        logic [4:0]  b;
        repeat (8) begin
            rnd = $urandom;
            a = rnd[4:0];
            b = rnd[9:5];
            writeReg(a, $urandom);
            writeReg(b, $urandom);
            loadInstr({6'h00, a, b, 5'd3, 5'd0, 6'h25});   // or r3, a, b
            @(negedge clk);
            checkVal("busA", busA, refRegs[a]);
            checkVal("busB", busB, refRegs[b]);
            nextCycle();
        end
        writeReg(5'd0, 32'h5a5a_a5a5);
        loadInstr({6'h00, 5'd0, 5'd0, 5'd3, 5'd0, 6'h21});
        @(negedge clk);
        checkVal("busA", busA, 32'h0);
        checkVal("busB", busB, 32'h0);
        nextCycle();
    endtask

    task automatic testBypass();
        logic [31:0] rnd;
        logic [4:0]  r;
        rnd = $urandom;
        r = rnd[4:0] | 5'd1;        // any nonzero register
        loadInstr({6'h00, r, r, 5'd2, 5'd0, 6'h21});
        memDst = r;
        mem2Dst = r;
        wbDst = r;
        memResult = $urandom;
        mem2Result = $urandom;
        wbResult = $urandom;
        {memRegWrite, mem2RegWrite, wbRegWrite} = 3'b111;
        @(negedge clk);
        checkVal("busA", busA, memResult);
        checkVal("busB", busB, memResult);
        nextCycle();
        memRegWrite = 1'b0;
        @(negedge clk);
        checkVal("busA", busA, mem2Result);
        checkVal("busB", busB, mem2Result);
        nextCycle();
        mem2RegWrite = 1'b0;
        wbResult = $urandom;        // r still holds the older WB value
        @(negedge clk);
        checkVal("busA", busA, wbResult);
        checkVal("busB", busB, wbResult);
        nextCycle();
        wbRegWrite = 1'b0;          // WB has written r by now
        wbResult = $urandom;
        @(negedge clk);
        checkVal("busA", busA, refRegs[r]);
        checkVal("busB", busB, refRegs[r]);
        nextCycle();
        loadInstr({6'h00, 5'd0, 5'd0, 5'd2, 5'd0, 6'h21});
        {memDst, mem2Dst, wbDst} = '0;
        {memRegWrite, mem2RegWrite, wbRegWrite} = 3'b111;
        @(negedge clk);
        checkVal("busA", busA, 32'h0);
        checkVal("busB", busB, 32'h0);
        nextCycle();
        {memRegWrite, mem2RegWrite, wbRegWrite} = 3'b000;
    endtask

    task automatic expectStall(input logic e, input logic m);
        @(negedge clk);
        checkVal("exeStall", exeStall, e);
        checkVal("memStall", memStall, m);
        nextCycle();
    endtask

    task automatic testHazard();
        loadInstr({6'h00, 5'd5, 5'd6, 5'd7, 5'd0, 6'h21});   // addu r7, r5, r6
        exeMemRead = 1'b1;
        exeRt = 5'd6;
        expectStall(1'b1, 1'b0);
        exeMemRead = 1'b0;
        memMemRead = 1'b1;
        memRt = 5'd5;
        expectStall(1'b0, 1'b1);
        exeMemRead = 1'b1;
        exeRt = 5'd5;
        expectStall(1'b1, 1'b1);
        {exeMemRead, memMemRead} = 2'b00;     // same targets, no loads
        expectStall(1'b0, 1'b0);
        loadInstr({6'h09, 5'd5, 5'd6, 16'h0004});            // addiu, rt not read
        exeMemRead = 1'b1;
        exeRt = 5'd6;
        expectStall(1'b0, 1'b0);
        loadInstr({6'h00, 5'd0, 5'd6, 5'd7, 5'd0, 6'h21});   // rs is r0
        exeRt = 5'd0;
        memMemRead = 1'b1;
        memRt = 5'd0;
        expectStall(1'b0, 1'b0);
        {exeMemRead, memMemRead} = 2'b00;
    endtask

    task automatic checkDisabled(input logic [31:0] ins);
        loadInstr(ins);
        predict(ins);
        @(negedge clk);
        checkVal("{regWrite, memRead, memWrite}", {regWrite, memRead, memWrite}, 3'b000);
        checkVal("aluOp", aluOp, expAlu);
        checkVal("dst", dst, expDst);
        nextCycle();
    endtask

    task automatic testDisableWr();
        disableWr = 1'b1;
        checkDisabled(32'h8ca4_0010);   // lw
        checkDisabled(32'hacc7_fffc);   // sw
        checkDisabled({6'h00, 5'd1, 5'd2, 5'd9, 5'd0, 6'h21});
        disableWr = 1'b0;
    endtask

    initial begin
        seedVal = $urandom(32'h9ca0);
        arstN = 1'b0;
        {idWr, idFlush, disableWr, memRegWrite, mem2RegWrite} = '0;
        {wbRegWrite, exeMemRead, memMemRead} = '0;
        {memDst, mem2Dst, wbDst, exeRt, memRt} = '0;
        {ifInstr, memResult, mem2Result, wbResult} = '0;
        ifPc = 32'h0040_0000;
        repeat (10) @(posedge clk);
        #1;
        arstN = 1'b1;
        testReset();
        testDecode();
        testRegFile();
        testBypass();
        testHazard();
        testDisableWr();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(testCycles * 20 * clkPeriod);
        $display("timeout, the tests did not finish");
        $display("test failed");
        $finish;
    end

endmodule

//--- compile.f
common/cpuPkg.sv
decode/idReg.sv
decode/regFile.sv
decode/instrDecoder.sv
decode/bypassUnit.sv
decode/loadHazard.sv
decode/decodeStage.sv
bench/decodeStage_chk.sv
bench/decodeStage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert -Wno-fatal --top-module decodeStage_tb \
    -f compile.f -Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "test failed" "$logFile"; then
    exit 1
fi
exit 0
